//--- filelist.f
+incdir+.
tnet_pkg.sv
tnet_cmd_intake.sv
tnet_cmd_fifo.sv
tnet_cmd_exec.sv
tnet_node.sv
tb_tnet_node.sv

//--- Makefile
# Verilator build and run for the time-distribution node

VERILATOR  ?= verilator
TOP        ?= tb_tnet_node
LINT_TOP   ?= tnet_node
FILELIST   ?= filelist.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# Pass only when the log holds the pass message
run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "STATUS: PASS" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(LINT_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb_tnet_tasks.svh
`ifndef TB_TNET_TASKS_SVH
`define TB_TNET_TASKS_SVH

//////////////////////////////////////////////////
// Frame helpers

function automatic tnet_frame_t build_frame(
   input tnet_op_e                op,
   input logic [`TNET_FLG_W-1:0]  flg,
   input logic [`TNET_ID_W-1:0]   dst,
   input logic [`TNET_ID_W-1:0]   src,
   input logic [`TNET_WORD_W-1:0] d0,
   input logic [`TNET_WORD_W-1:0] d1,
   input logic [`TNET_WORD_W-1:0] d2);
   tnet_frame_t f;
   f          = '0;
   f.hdr.op   = op;
   f.hdr.flg  = flg;
   f.hdr.dst  = dst;
   f.hdr.src  = src;
   f.data.dt0 = d0;
   f.data.dt1 = d1;
   f.data.dt2 = d2;
   return f;
endfunction

// Answer to a get_dt request built from the model state
function automatic tnet_frame_t expected_reply(input tnet_frame_t req);
   tnet_frame_t r;
   r          = req;
   r.hdr.flg  = req.hdr.flg | FLG_RESP;
   r.hdr.dst  = req.hdr.src;
   r.hdr.src  = m_param.id;
   r.data.dt0 = m_param.dt0;
   r.data.dt1 = m_param.dt1;
   r.data.dt2 = '0;
   return r;
endfunction

//////////////////////////////////////////////////
// Bus drivers and waits

task automatic send_rx(input tnet_frame_t f);
   @(posedge t_clk);
   rx_frame_i <= f;
   rx_valid_i <= 1'b1;
   @(posedge t_clk);
   rx_valid_i <= 1'b0;
endtask

task automatic wait_ready();
   int n;
   n = 0;
   @(negedge t_clk);
   while (!c_ready_o) begin
      if (n >= TMO_CYCLES) begin
         abort_run($sformatf("Timeout in %s, c_ready_o never returned high", cur_test));
      end
      n++;
      @(negedge t_clk);
   end
endtask

task automatic issue_local(input tnet_op_e op, input tnet_data_t dt);
   wait_ready();
   @(posedge t_clk);
   c_cmd_i <= 1'b1;
   c_op_i  <= op;
   c_dt_i  <= dt;
   @(posedge t_clk);
   c_cmd_i <= 1'b0;
   @(negedge t_clk);
   check_val("c_ready_o low while pending", 1'b0, c_ready_o);
   wait_ready();
endtask

task automatic wait_tx(output tnet_frame_t f);
   int n;
   n = 0;
   while (tx_q.size() == 0) begin
      if (n >= TMO_CYCLES) begin
         abort_run($sformatf("Timeout in %s, no TX frame was sent", cur_test));
      end
      n++;
      @(posedge t_clk);
   end
   f = tx_q.pop_front();
endtask

task automatic expect_tx(input string what, input tnet_frame_t exp);
   tnet_frame_t got;
   wait_tx(got);
   check_val(what, exp, got);
endtask

// A get_dt request marks the end of earlier silent commands
task automatic fence_get_dt(input string what);
   tnet_frame_t f;
   f = build_frame(OP_GET_DT, '0, m_param.id, 9'h00A, '0, '0, '0);
   send_rx(f);
   expect_tx(what, expected_reply(f));
   check_val("no other TX frame", 0, tx_q.size());
endtask

//////////////////////////////////////////////////
// Directed tests

task automatic set_net_test();
   tnet_frame_t f;
   tnet_frame_t exp;
   cur_test = "set_net";
   f = build_frame(OP_SET_NET, '0, BCAST, 9'h001, '0, 32'h0000_0040, 32'h0010_0005);
   send_rx(f);
   m_param.id = f.data.dt2[8:0];
   m_param.nn = f.data.dt2[24:16];
   m_param.cd = f.data.dt1;
   // Next node gets the ID counter plus one
   exp = f;
   exp.data.dt2[8:0] = f.data.dt2[8:0] + 9'd1;
   expect_tx("forwarded frame", exp);
   @(negedge t_clk);
   check_val("single TX frame", 0, tx_q.size());
   check_val("net_param_o", m_param, net_param_o);
endtask

task automatic sync_net_test();
   tnet_frame_t f;
   tnet_frame_t exp;
   int          i0;
   int          u0;
   cur_test = "sync_net";
   i0 = init_cnt;
   u0 = updt_cnt;
   f = build_frame(OP_SYNC_NET, '0, m_param.id, 9'h001, 32'h0000_1000, 32'h0000_0200, '0);
   send_rx(f);
   m_off = f.data.dt0 + f.data.dt1;
   exp = f;
   exp.data.dt0 = f.data.dt0 + m_param.cd;
   expect_tx("forwarded frame", exp);
   @(negedge t_clk);
   check_val("single TX frame", 0, tx_q.size());
   check_val("time_init_o pulses", 1, init_cnt - i0);
   check_val("time_updt_o pulses", 0, updt_cnt - u0);
   check_val("time_off_dt_o", m_off, time_off_dt_o);
endtask

task automatic updt_set_dt_test();
   tnet_frame_t f;
   int          i0;
   int          u0;
   cur_test = "updt_off_set_dt";
   i0 = init_cnt;
   u0 = updt_cnt;
   f = build_frame(OP_UPDT_OFF, '0, m_param.id, 9'h002, 32'h0000_3333, 32'hDEAD_0000, '0);
   send_rx(f);
   m_off = f.data.dt0;
   f = build_frame(OP_SET_DT, '0, m_param.id, 9'h002, 32'hAAAA_0001, 32'hBBBB_0002,
                   32'hCCCC_0003);
   send_rx(f);
   m_param.dt0 = f.data.dt0;
   m_param.dt1 = f.data.dt1;
   fence_get_dt("reply with stored words");
   @(negedge t_clk);
   check_val("time_updt_o pulses", 1, updt_cnt - u0);
   check_val("time_init_o pulses", 0, init_cnt - i0);
   check_val("time_off_dt_o", m_off, time_off_dt_o);
   check_val("net_param_o", m_param, net_param_o);
endtask

task automatic get_dt_test();
   tnet_frame_t f;
   cur_test = "get_dt";
   @(posedge t_clk);
   stall_en <= 1'b1;
   f = build_frame(OP_GET_DT, '0, m_param.id, 9'h00A, 32'h5555_5555, 32'h6666_6666,
                   32'h7777_7777);
   send_rx(f);
   expect_tx("reply under back-pressure", expected_reply(f));
   @(posedge t_clk);
   stall_en <= 1'b0;
   // Response addressed to this node is stored and not answered
   f = build_frame(OP_GET_DT, FLG_RESP, m_param.id, 9'h00A, 32'h1234_5678, 32'h9ABC_DEF0,
                   '0);
   send_rx(f);
   m_param.dt0 = f.data.dt0;
   m_param.dt1 = f.data.dt1;
   fence_get_dt("reply with received words");
   @(negedge t_clk);
   check_val("net_param_o", m_param, net_param_o);
endtask

task automatic local_cmd_test();
   tnet_data_t  d;
   tnet_frame_t e_sync;
   tnet_frame_t e_set;
   tnet_frame_t e_get;
   int          i0;
   int          u0;
   cur_test = "local_cmd";
   i0 = init_cnt;
   u0 = updt_cnt;
   e_sync = build_frame(OP_SYNC_NET, '0, BCAST, m_param.id, m_param.cd, '0, '0);
   e_set  = build_frame(OP_SET_DT, '0, 9'h007, m_param.id, 32'h0000_1111, 32'h0000_2222, '0);
   e_get  = build_frame(OP_GET_DT, '0, 9'h00A, m_param.id, '0, '0, '0);
   d = '{dt0: 32'h0000_FFFF, dt1: 32'h0000_EEEE, dt2: 32'h0003_0000};
   issue_local(OP_SYNC_NET, d);
   d = '{dt0: 32'h0000_1111, dt1: 32'h0000_2222, dt2: 32'h0007_0000};
   issue_local(OP_SET_DT, d);
   d = '{dt0: 32'h0000_0003, dt1: 32'h0000_0004, dt2: 32'h000A_0000};
   issue_local(OP_GET_DT, d);
   expect_tx("local sync_net frame", e_sync);
   expect_tx("local set_dt frame", e_set);
   expect_tx("local get_dt frame", e_get);
   @(negedge t_clk);
   check_val("no time pulses", 0, (init_cnt - i0) + (updt_cnt - u0));
   check_val("net_param_o", m_param, net_param_o);
endtask

task automatic dst_filter_test();
   tnet_frame_t f;
   int          i0;
   int          u0;
   cur_test = "dst_filter";
   i0 = init_cnt;
   u0 = updt_cnt;
   f = build_frame(OP_SET_NET, '0, 9'h033, 9'h002, '0, 32'h0000_0999, 32'h0020_0030);
   send_rx(f);
   f = build_frame(OP_UPDT_OFF, '0, 9'h034, 9'h002, 32'h0000_7777, '0, '0);
   send_rx(f);
   fence_get_dt("reply after dropped frames");
   @(negedge t_clk);
   check_val("no time pulses", 0, (init_cnt - i0) + (updt_cnt - u0));
   check_val("net_param_o", m_param, net_param_o);
   check_val("time_off_dt_o", m_off, time_off_dt_o);
endtask

`endif

//--- tb_tnet_node.sv
`timescale 1ns/100ps
`default_nettype none

`include "tnet_cfg.svh"

module tb_tnet_node import tnet_pkg::*; ();

   localparam int CLK_PERIOD  = 10;
   localparam int RST_CYCLES  = 5;
   localparam int TMO_CYCLES  = 200;
   localparam int N_TESTS     = 6;
   // Each test waits on at most a handful of events
   localparam int WDOG_CYCLES = RST_CYCLES + N_TESTS * 8 * TMO_CYCLES;

   localparam logic [`TNET_ID_W-1:0]  BCAST    = `TNET_BCAST_ID;
   localparam logic [`TNET_FLG_W-1:0] FLG_RESP = `TNET_FLG_W'(1) << `TNET_FLG_RESP;

   logic                    t_clk;
   logic                    t_aresetn;
   logic                    c_cmd_i;
   tnet_op_e                c_op_i;
   tnet_data_t              c_dt_i;
   logic                    c_ready_o;
   tnet_frame_t             rx_frame_i;
   logic                    rx_valid_i;
   tnet_frame_t             tx_frame_o;
   logic                    tx_valid_o;
   logic                    tx_ready_i;
   logic                    time_init_o;
   logic                    time_updt_o;
   logic [`TNET_WORD_W-1:0] time_off_dt_o;
   tnet_param_t             net_param_o;
   logic                    rx_overflow_o;

   // Monitor bookkeeping
   tnet_frame_t             tx_q[$];
   int                      init_cnt;
   int                      updt_cnt;
   logic                    held_vld;
   tnet_frame_t             held_frame;

   // Back-pressure generator
   logic                    stall_en;
   int                      hold_cnt;
   logic [31:0]             lfsr_q;

   // Reference model of the node state
   string                   cur_test;
   tnet_param_t             m_param;
   logic [`TNET_WORD_W-1:0] m_off;

   tnet_node i_tnet_node (
      .t_clk (t_clk), .t_aresetn (t_aresetn),
      .c_cmd_i (c_cmd_i), .c_op_i (c_op_i), .c_dt_i (c_dt_i), .c_ready_o (c_ready_o),
      .rx_frame_i (rx_frame_i), .rx_valid_i (rx_valid_i),
      .tx_frame_o (tx_frame_o), .tx_valid_o (tx_valid_o), .tx_ready_i (tx_ready_i),
      .time_init_o (time_init_o), .time_updt_o (time_updt_o),
      .time_off_dt_o (time_off_dt_o), .net_param_o (net_param_o),
      .rx_overflow_o (rx_overflow_o));

   always #(CLK_PERIOD / 2) t_clk = ~t_clk;

   //////////////////////////////////////////////////
   // Error handling

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("STATUS: FAIL");
      $fatal(1, "Simulation stopped on error");
   endtask

   task automatic check_val(input string what, input logic [127:0] exp,
                            input logic [127:0] act);
      if (exp !== act) begin
         abort_run($sformatf("Fail %s: %s expected %0h actual %0h",
                             cur_test, what, exp, act));
      end
   endtask

   //////////////////////////////////////////////////
   // Random ready stalls

   // Right-shift Galois form
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
   endfunction

   // Ready stays low for one or two cycles of every valid frame
   always @(posedge t_clk) begin : ready_gen
      logic [31:0] nxt;
      if (!stall_en) begin
         tx_ready_i <= 1'b1;
         hold_cnt   <= 0;
      end else if (tx_valid_o && !tx_ready_i) begin
         if (hold_cnt == 0) begin
            tx_ready_i <= 1'b1;
         end else begin
            hold_cnt <= hold_cnt - 1;
         end
      end else begin
         nxt = lfsr_step(lfsr_q);
         lfsr_q     <= nxt;
         tx_ready_i <= 1'b0;
         hold_cnt   <= int'(nxt[0]);
      end
   end

   //////////////////////////////////////////////////
   // Output monitor sampled between edges
   always @(negedge t_clk) begin
      if (t_aresetn) begin
         if (held_vld) begin
            check_val("tx_valid_o held during stall", 1'b1, tx_valid_o);
            check_val("tx_frame_o held during stall", held_frame, tx_frame_o);
         end
         held_vld   = tx_valid_o && !tx_ready_i;
         held_frame = tx_frame_o;
         if (tx_valid_o && tx_ready_i) begin
            tx_q.push_back(tx_frame_o);
         end
         if (time_init_o) begin
            init_cnt++;
         end
         if (time_updt_o) begin
            updt_cnt++;
         end
      end
   end

   `include "tb_tnet_tasks.svh"

   initial begin
      #(WDOG_CYCLES * CLK_PERIOD);
      abort_run("Watchdog expired before the test sequence finished");
   end

   //////////////////////////////////////////////////
   // Test sequence
   initial begin
      t_clk      = 1'b0;
      t_aresetn  = 1'b0;
      c_cmd_i    = 1'b0;
      c_op_i     = OP_SET_NET;
      c_dt_i     = '0;
      rx_frame_i = '0;
      rx_valid_i = 1'b0;
      tx_ready_i = 1'b1;
      stall_en   = 1'b0;
      hold_cnt   = 0;
      lfsr_q     = 32'h242;
      init_cnt   = 0;
      updt_cnt   = 0;
      held_vld   = 1'b0;
      held_frame = '0;
      m_param    = '0;
      m_off      = '0;
      cur_test   = "reset";

      repeat (RST_CYCLES) @(posedge t_clk);
      t_aresetn <= 1'b1;
      @(negedge t_clk);
      check_val("c_ready_o", 1'b1, c_ready_o);
      check_val("tx_valid_o", 1'b0, tx_valid_o);
      check_val("time pulses", 2'b00, {time_init_o, time_updt_o});
      check_val("rx_overflow_o", 1'b0, rx_overflow_o);
      check_val("net_param_o", m_param, net_param_o);
      check_val("time_off_dt_o", m_off, time_off_dt_o);

      set_net_test();
      sync_net_test();
      updt_set_dt_test();
      get_dt_test();
      local_cmd_test();
      dst_filter_test();

      cur_test = "end";
      @(negedge t_clk);
      check_val("rx_overflow_o", 1'b0, rx_overflow_o);
      $display("STATUS: PASS");
      $finish;
   end

endmodule

`default_nettype wire

//--- tnet_node.sv
`timescale 1ns/100ps
`default_nettype none

`include "tnet_cfg.svh"

module tnet_node import tnet_pkg::*; (
   input  wire         t_clk,
   input  wire         t_aresetn,
   // Local processor commands
   input  wire         c_cmd_i,
   input  wire tnet_op_e    c_op_i,
   input  wire tnet_data_t  c_dt_i,
   output logic        c_ready_o,
   // Network link
   input  wire tnet_frame_t rx_frame_i,
   input  wire         rx_valid_i,
   output tnet_frame_t tx_frame_o,
   output logic        tx_valid_o,
   input  wire         tx_ready_i,
   // Time base and status
   output logic        time_init_o,
   output logic        time_updt_o,
   output logic [`TNET_WORD_W-1:0] time_off_dt_o,
   output tnet_param_t net_param_o,
   output logic        rx_overflow_o
);

   logic        wr_en;
   tnet_frame_t wr_frame;
   logic        wr_local;
   logic        fifo_full;
   logic        rd_en;
   tnet_frame_t rd_frame;
   logic        rd_local;
   logic        not_empty;

   //////////////////////////////////////////////////
   // Producer, queue, consumer

   tnet_cmd_intake i_intake (
      .t_clk (t_clk), .t_aresetn (t_aresetn),
      .c_cmd_i (c_cmd_i), .c_op_i (c_op_i), .c_dt_i (c_dt_i), .c_ready_o (c_ready_o),
      .rx_frame_i (rx_frame_i), .rx_valid_i (rx_valid_i), .node_param_i (net_param_o),
      .fifo_full_i (fifo_full), .wr_en_o (wr_en), .wr_frame_o (wr_frame),
      .wr_local_o (wr_local), .rx_overflow_o (rx_overflow_o));

   tnet_cmd_fifo i_fifo (
      .t_clk (t_clk), .t_aresetn (t_aresetn),
      .wr_en_i (wr_en), .wr_frame_i (wr_frame), .wr_local_i (wr_local),
      .rd_en_i (rd_en), .rd_frame_o (rd_frame), .rd_local_o (rd_local),
      .not_empty_o (not_empty), .full_o (fifo_full));

   tnet_cmd_exec i_exec (
      .t_clk (t_clk), .t_aresetn (t_aresetn),
      .rd_frame_i (rd_frame), .rd_local_i (rd_local), .not_empty_i (not_empty),
      .rd_en_o (rd_en), .tx_frame_o (tx_frame_o), .tx_valid_o (tx_valid_o),
      .tx_ready_i (tx_ready_i), .time_init_o (time_init_o), .time_updt_o (time_updt_o),
      .time_off_dt_o (time_off_dt_o), .node_param_o (net_param_o));

endmodule

`default_nettype wire

//--- tnet_cmd_exec.sv
`timescale 1ns/100ps
`default_nettype none

`include "tnet_cfg.svh"

module tnet_cmd_exec import tnet_pkg::*; (
   input  wire         t_clk,
   input  wire         t_aresetn,
   // Queue read side
   input  wire tnet_frame_t rd_frame_i,
   input  wire         rd_local_i,
   input  wire         not_empty_i,
   output logic        rd_en_o,
   // TX stream
   output tnet_frame_t tx_frame_o,
   output logic        tx_valid_o,
   input  wire         tx_ready_i,
   // Time base control
   output logic        time_init_o,
   output logic        time_updt_o,
   output logic [`TNET_WORD_W-1:0] time_off_dt_o,
   output tnet_param_t node_param_o
);

   tnet_exec_st_e st_q;
   tnet_exec_st_e st_d;
   tnet_frame_t   cmd_q;
   logic          cmd_local_q;
   logic          dec_act;
   logic          send_d;
   logic          init_d;
   logic          updt_d;
   logic          off_ld;
   logic [`TNET_WORD_W-1:0] off_d;
   logic [`TNET_WORD_W-1:0] off_q;
   tnet_param_t   param_q;
   tnet_param_t   param_d;
   tnet_frame_t   tx_d;

   assign dec_act       = (st_q == EXEC_DECODE);
   assign time_init_o   = dec_act && init_d;
   assign time_updt_o   = dec_act && updt_d;
   assign time_off_dt_o = off_q;
   assign node_param_o  = param_q;

   //////////////////////////////////////////////////
   // FSM, one frame in flight
   always_comb begin
      st_d    = st_q;
      rd_en_o = 1'b0;
      case (st_q)
         EXEC_IDLE: begin
            if (not_empty_i) begin
               rd_en_o = 1'b1;
               st_d    = EXEC_DECODE;
            end
         end
         EXEC_DECODE: st_d = send_d ? EXEC_SEND : EXEC_IDLE;
         EXEC_SEND: begin
            if (tx_ready_i) begin
               st_d = EXEC_IDLE;
            end
         end
         default: st_d = EXEC_IDLE;
      endcase
   end

   //////////////////////////////////////////////////
   // Command decode
   always_comb begin
      send_d  = 1'b0;
      init_d  = 1'b0;
      updt_d  = 1'b0;
      off_ld  = 1'b0;
      off_d   = cmd_q.data.dt0;
      param_d = param_q;
      tx_d    = cmd_q;
      if (cmd_local_q) begin
         // Built by the intake, goes out as is
         send_d = 1'b1;
      end else begin
         case (cmd_q.hdr.op)
            OP_SET_NET: begin
               param_d.id        = cmd_q.data.dt2[8:0];
               param_d.nn        = cmd_q.data.dt2[24:16];
               param_d.cd        = cmd_q.data.dt1;
               // ID counter for the next node
               tx_d.data.dt2[8:0] = cmd_q.data.dt2[8:0] + 1'b1;
               send_d            = 1'b1;
            end
            OP_SYNC_NET: begin
               init_d        = 1'b1;
               off_ld        = 1'b1;
               off_d         = cmd_q.data.dt0 + cmd_q.data.dt1;
               tx_d.data.dt0 = cmd_q.data.dt0 + param_q.cd;
               send_d        = 1'b1;
            end
            OP_UPDT_OFF: begin
               updt_d = 1'b1;
               off_ld = 1'b1;
            end
            OP_SET_DT: begin
               param_d.dt0 = cmd_q.data.dt0;
               param_d.dt1 = cmd_q.data.dt1;
            end
            OP_GET_DT: begin
               if (cmd_q.hdr.flg[`TNET_FLG_RESP]) begin
                  param_d.dt0 = cmd_q.data.dt0;
                  param_d.dt1 = cmd_q.data.dt1;
               end else begin
                  // Answer the requester with the stored words
                  tx_d.hdr.flg[`TNET_FLG_RESP] = 1'b1;
                  tx_d.hdr.dst  = cmd_q.hdr.src;
                  tx_d.hdr.src  = param_q.id;
                  tx_d.data.dt0 = param_q.dt0;
                  tx_d.data.dt1 = param_q.dt1;
                  tx_d.data.dt2 = '0;
                  send_d        = 1'b1;
               end
            end
            default: ;
         endcase
      end
   end

   always_ff @(posedge t_clk) begin
      if (!t_aresetn) begin
         st_q       <= EXEC_IDLE;
         tx_valid_o <= 1'b0;
         param_q    <= '0;
         off_q      <= '0;
      end else begin
         st_q <= st_d;
         if (dec_act) begin
            param_q <= param_d;
            if (off_ld) begin
               off_q <= off_d;
            end
            tx_valid_o <= send_d;
         end else if (st_q == EXEC_SEND && tx_ready_i) begin
            tx_valid_o <= 1'b0;
         end
      end
   end

   always_ff @(posedge t_clk) begin
      if (rd_en_o) begin
         cmd_q       <= rd_frame_i;
         cmd_local_q <= rd_local_i;
      end
      if (dec_act && send_d) begin
         tx_frame_o <= tx_d;
      end
   end

   a_tx_hold: assert property (@(posedge t_clk) disable iff (!t_aresetn)
      tx_valid_o && !tx_ready_i |=> tx_valid_o && $stable(tx_frame_o));

endmodule

`default_nettype wire

//--- tnet_cmd_fifo.sv
`timescale 1ns/100ps
`default_nettype none

`include "tnet_cfg.svh"

module tnet_cmd_fifo import tnet_pkg::*; (
   input  wire         t_clk,
   input  wire         t_aresetn,
   input  wire         wr_en_i,
   input  wire tnet_frame_t wr_frame_i,
   input  wire         wr_local_i,
   input  wire         rd_en_i,
   output tnet_frame_t rd_frame_o,
   output logic        rd_local_o,
   output logic        not_empty_o,
   output logic        full_o
);

   localparam int DEPTH = `TNET_FIFO_DEPTH;
   localparam int PTR_W = $clog2(DEPTH);
   localparam int CNT_W = $clog2(DEPTH + 1);

   tnet_frame_t      mem_frame [DEPTH];
   logic             mem_local [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;

   // Head entry shows without a read cycle
   assign rd_frame_o  = mem_frame[rd_ptr];
   assign rd_local_o  = mem_local[rd_ptr];
   assign not_empty_o = (count != '0);
   assign full_o      = (count == CNT_W'(DEPTH));

   always_ff @(posedge t_clk) begin
      if (wr_en_i) begin
         mem_frame[wr_ptr] <= wr_frame_i;
         mem_local[wr_ptr] <= wr_local_i;
      end
   end

   //////////////////////////////////////////////////
   // Pointers and fill count
   always_ff @(posedge t_clk) begin
      if (!t_aresetn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (wr_en_i) begin
            wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (rd_en_i) begin
            rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         if (wr_en_i && !rd_en_i) begin
            count <= count + 1'b1;
         end else if (rd_en_i && !wr_en_i) begin
            count <= count - 1'b1;
         end
      end
   end

   a_no_underflow: assert property (@(posedge t_clk) disable iff (!t_aresetn)
      rd_en_i |-> not_empty_o);
   a_no_overflow: assert property (@(posedge t_clk) disable iff (!t_aresetn)
      wr_en_i |-> !full_o);

endmodule

`default_nettype wire

//--- tnet_cmd_intake.sv
`timescale 1ns/100ps
`default_nettype none

`include "tnet_cfg.svh"

module tnet_cmd_intake import tnet_pkg::*; (
   input  wire         t_clk,
   input  wire         t_aresetn,
   // Local processor
   input  wire         c_cmd_i,
   input  wire tnet_op_e    c_op_i,
   input  wire tnet_data_t  c_dt_i,
   output logic        c_ready_o,
   // Network receive
   input  wire tnet_frame_t rx_frame_i,
   input  wire         rx_valid_i,
   input  wire tnet_param_t node_param_i,
   // Queue write side
   input  wire         fifo_full_i,
   output logic        wr_en_o,
   output tnet_frame_t wr_frame_o,
   output logic        wr_local_o,
   output logic        rx_overflow_o
);

   logic        pend_q;
   tnet_op_e    pend_op_q;
   tnet_data_t  pend_dt_q;
   logic        rx_vld_q;
   tnet_frame_t rx_frame_q;
   logic        rx_hit;
   logic        loc_take;
   tnet_frame_t loc_frame;

   //////////////////////////////////////////////////
   // RX destination filter

   assign rx_hit = rx_valid_i &&
                   ((rx_frame_i.hdr.dst == node_param_i.id) ||
                    (rx_frame_i.hdr.dst == `TNET_BCAST_ID));

   // Pending local request blocks new strobes
   assign c_ready_o = !pend_q;

   // RX wins the write slot
   assign loc_take   = pend_q && !rx_vld_q && !fifo_full_i;
   assign wr_en_o    = (rx_vld_q || pend_q) && !fifo_full_i;
   assign wr_local_o = !rx_vld_q;
   assign wr_frame_o = rx_vld_q ? rx_frame_q : loc_frame;

   //////////////////////////////////////////////////
   // Local frame builder
   always_comb begin
      loc_frame          = '0;
      loc_frame.hdr.op   = pend_op_q;
      loc_frame.hdr.src  = node_param_i.id;
      loc_frame.hdr.dst  = pend_dt_q.dt2[24:16];
      loc_frame.data     = pend_dt_q;
      case (pend_op_q)
         OP_SYNC_NET: begin
            loc_frame.hdr.dst  = `TNET_BCAST_ID;
            loc_frame.data     = '0;
            loc_frame.data.dt0 = node_param_i.cd;
         end
         OP_SET_DT: begin
            loc_frame.data.dt2 = '0;
         end
         OP_GET_DT: begin
            loc_frame.data = '0;
         end
         default: ;
      endcase
   end

   always_ff @(posedge t_clk) begin
      if (!t_aresetn) begin
         pend_q        <= 1'b0;
         rx_vld_q      <= 1'b0;
         rx_overflow_o <= 1'b0;
      end else begin
         rx_vld_q <= rx_hit;
         if (c_cmd_i && c_ready_o) begin
            pend_q <= 1'b1;
         end else if (loc_take) begin
            pend_q <= 1'b0;
         end
         // Frame dropped on a full queue
         if (rx_vld_q && fifo_full_i) begin
            rx_overflow_o <= 1'b1;
         end
      end
   end

   always_ff @(posedge t_clk) begin
      rx_frame_q <= rx_frame_i;
      if (c_cmd_i && c_ready_o) begin
         pend_op_q <= c_op_i;
         pend_dt_q <= c_dt_i;
      end
   end

endmodule

`default_nettype wire

//--- tnet_pkg.sv
`default_nettype none

`include "tnet_cfg.svh"

package tnet_pkg;

   //////////////////////////////////////////////////
   // Opcodes, same encoding as the network nodes
   typedef enum logic [`TNET_OP_W-1:0] {
      OP_SET_NET  = 5'b00010,
      OP_SYNC_NET = 5'b01000,
      OP_UPDT_OFF = 5'b01001,
      OP_SET_DT   = 5'b01010,
      OP_GET_DT   = 5'b01011
   } tnet_op_e;

   //////////////////////////////////////////////////
   // Frame layout

   // 32-bit header
   typedef struct packed {
      logic [2:0]            spare;
      tnet_op_e              op;
      logic [`TNET_FLG_W-1:0] flg;
      logic [`TNET_ID_W-1:0]  dst;
      logic [`TNET_ID_W-1:0]  src;
   } tnet_hdr_t;

   typedef struct packed {
      logic [`TNET_WORD_W-1:0] dt0;
      logic [`TNET_WORD_W-1:0] dt1;
      logic [`TNET_WORD_W-1:0] dt2;
   } tnet_data_t;

   // Queue entry and link frame, header on top
   typedef struct packed {
      tnet_hdr_t  hdr;
      tnet_data_t data;
   } tnet_frame_t;

   //////////////////////////////////////////////////
   // Node parameter set
   typedef struct packed {
      logic [`TNET_ID_W-1:0]   id;
      logic [`TNET_ID_W-1:0]   nn;
      logic [`TNET_WORD_W-1:0] cd;
      logic [`TNET_WORD_W-1:0] dt0;
      logic [`TNET_WORD_W-1:0] dt1;
   } tnet_param_t;

   // Executor FSM
   typedef enum logic [1:0] {
      EXEC_IDLE,
      EXEC_DECODE,
      EXEC_SEND
   } tnet_exec_st_e;

endpackage

`default_nettype wire

//--- tnet_cfg.svh
`ifndef TNET_CFG_SVH
`define TNET_CFG_SVH

//////////////////////////////////////////////////
// Field widths

// Node ID and node count
`define TNET_ID_W        9

// Payload data word
`define TNET_WORD_W      32

// Header opcode and flag fields
`define TNET_OP_W        5
`define TNET_FLG_W       6

//////////////////////////////////////////////////
// Addressing and flags

// Destination accepted by every node
`define TNET_BCAST_ID    {(`TNET_ID_W){1'b1}}

// Flag bit marking a response frame
`define TNET_FLG_RESP    0

//////////////////////////////////////////////////
// Command queue
`define TNET_FIFO_DEPTH  4

`endif
